// File: hdl/adxl_log_consts.svh
// constants for the adxl355 sample logger
// ram size and address width, sensor spi divider,
// sample clock accumulator, burst length and command codes
`ifndef ADXL_LOG_CONSTS_SVH
`define ADXL_LOG_CONSTS_SVH

// sample ring
`define ADXL_RAM_LEN    6144     // bytes, 1024 bursts of 6 kept bytes
`define ADXL_ADDR_BITS  13       // enough for ADXL_RAM_LEN

// sensor spi
`define ADXL_SCLK_DIV   4        // clk cycles per sclk half-period
`define ADXL_BURST_LEN  9        // data bytes per burst, x/y/z 3 bytes each
`define ADXL_READ_CMD   8'h11    // reg 0x08 shifted left, read bit set

// sample clock phase accumulator
`define ADXL_PA_BITS    16
`define ADXL_PA_INC     128      // msb period 65536/128 = 512 clk

// host spi commands
`define HOST_CMD_RAM    8'h01    // stream ram bytes from address
`define HOST_CMD_PTR    8'h02    // write pointer, high byte first
`define HOST_CMD_PPS    8'h03    // samples per pps interval

`endif

// File: hdl/adxl_log_pkg.sv
// shared types for the adxl355 sample logger
// data byte, ring address and host command codes
`include "adxl_log_consts.svh"

package adxl_log_pkg;

  // one byte as stored in the ring and moved over spi
  typedef logic [7:0] byte_t;

  // ring address, wraps at ADXL_RAM_LEN
  typedef logic [`ADXL_ADDR_BITS-1:0] ram_addr_t;

  // first byte of every host transfer
  typedef enum logic [7:0]
  {
    cmd_ram = `HOST_CMD_RAM,  // ram stream, address follows
    cmd_ptr = `HOST_CMD_PTR,  // current write pointer
    cmd_pps = `HOST_CMD_PPS   // last pps sample count
  } host_cmd_e;

  // any other code reads back as 8'hff

endpackage

// File: hdl/sync_nco.sv
`timescale 1ns/100ps
// sample clock generator for the adxl355 sync/drdy input
// phase accumulator msb as sample clock, rising edge pulse,
// sample pulse count latched on each pps rising edge
`include "adxl_log_consts.svh"

module sync_nco
(
  input  logic        clk,
  input  logic        reset,
  input  logic        pps,         // async, from host
  output logic        drdy,        // to sensor sync pin
  output logic        sync_pulse,  // one clk per sample
  output logic [15:0] pps_count    // samples in last pps interval
);

  logic [`ADXL_PA_BITS-1:0] acc;   // phase accumulator
  logic                     drdy_d1;
  logic                     drdy_d2;
  logic [2:0]               pps_s; // 2 sync flops + edge history
  logic                     pps_rise;
  logic [15:0]              sync_cnt;

  assign drdy     = acc[`ADXL_PA_BITS-1];  // msb is the sample clock
  assign pps_rise = pps_s[1] & ~pps_s[2];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      acc        <= '0;
      drdy_d1    <= 1'b0;
      drdy_d2    <= 1'b0;
      sync_pulse <= 1'b0;
      pps_s      <= '0;
      sync_cnt   <= '0;
      pps_count  <= '0;
    end
    else
    begin
      acc <= acc + `ADXL_PA_BITS'(`ADXL_PA_INC);

      // rising edge of msb, pulse lands 2 clk after the edge
      drdy_d1    <= drdy;
      drdy_d2    <= drdy_d1;
      sync_pulse <= drdy_d1 & ~drdy_d2;

      pps_s <= {pps_s[1:0], pps};

      // latch and restart on pps, a coincident sample starts the new interval
      if (pps_rise)
      begin
        pps_count <= sync_cnt;
        sync_cnt  <= {15'd0, sync_pulse};
      end
      else if (sync_pulse)
        sync_cnt <= sync_cnt + 1'b1;
    end
  end

endmodule

// File: hdl/adxl355_reader.sv
`timescale 1ns/100ps
// adxl355 burst reader, spi master mode 0, msb first
// per sample pulse: read command then ADXL_BURST_LEN data bytes
// two upper bytes of each axis go out as wr strobes, third is dropped
`include "adxl_log_consts.svh"

module adxl355_reader
(
  input  logic                clk,
  input  logic                reset,
  input  logic                sync_pulse,  // start a burst when idle
  input  logic                adxl_miso,
  output logic                adxl_csn,
  output logic                adxl_sclk,
  output logic                adxl_mosi,
  output logic                wr,          // one clk per kept byte
  output adxl_log_pkg::byte_t wr_data
);

  localparam logic [1:0] st_idle    = 2'd0;
  localparam logic [1:0] st_command = 2'd1;
  localparam logic [1:0] st_data    = 2'd2;
  localparam logic [1:0] st_finish  = 2'd3;

  localparam int div_bits = $clog2(`ADXL_SCLK_DIV);
  localparam adxl_log_pkg::byte_t read_cmd = `ADXL_READ_CMD;

  logic [1:0]          state;
  logic [div_bits-1:0] div_cnt;  // half-period divider
  logic                tick;     // sclk toggles here
  logic [2:0]          bit_cnt;
  logic [3:0]          byte_cnt; // data bytes done
  logic [1:0]          tri_cnt;  // byte position within an axis
  logic                fin_wait;
  adxl_log_pkg::byte_t tx_sr;
  adxl_log_pkg::byte_t rx_sr;

  assign tick = (div_cnt == div_bits'(`ADXL_SCLK_DIV - 1));

  // divider held at 0 while idle so every burst starts aligned
  always_ff @(posedge clk)
  begin
    if (reset || state == st_idle || tick)
      div_cnt <= '0;
    else
      div_cnt <= div_cnt + 1'b1;
  end

  always_ff @(posedge clk)
  begin
    wr <= 1'b0; // strobe
    if (reset)
    begin
      state     <= st_idle;
      adxl_csn  <= 1'b1;
      adxl_sclk <= 1'b0;
      adxl_mosi <= 1'b0;
      bit_cnt   <= '0;
      byte_cnt  <= '0;
      tri_cnt   <= '0;
      fin_wait  <= 1'b0;
    end
    else
    begin
      case (state)
        st_idle:
          if (sync_pulse)
          begin
            adxl_csn  <= 1'b0;        // 1 clk after the pulse
            adxl_mosi <= read_cmd[7]; // first bit ahead of first rising edge
            tx_sr     <= read_cmd;
            bit_cnt   <= '0;
            byte_cnt  <= '0;
            tri_cnt   <= '0;
            fin_wait  <= 1'b0;
            state     <= st_command;
          end
        st_command, st_data:
          if (tick)
          begin
            adxl_sclk <= ~adxl_sclk;
            if (!adxl_sclk)
              rx_sr <= {rx_sr[6:0], adxl_miso}; // sample on rising edge
            else
            begin
              // falling edge closes the bit, next mosi bit goes out
              tx_sr     <= {tx_sr[6:0], 1'b0};
              adxl_mosi <= tx_sr[6];
              bit_cnt   <= bit_cnt + 1'b1;
              if (bit_cnt == 3'd7)
              begin
                if (state == st_command)
                  state <= st_data;
                else
                begin
                  wr_data  <= rx_sr;
                  wr       <= (tri_cnt != 2'd2); // lowest axis byte dropped
                  tri_cnt  <= (tri_cnt == 2'd2) ? 2'd0 : tri_cnt + 1'b1;
                  byte_cnt <= byte_cnt + 1'b1;
                  if (byte_cnt == 4'(`ADXL_BURST_LEN - 1))
                    state <= st_finish;
                end
              end
            end
          end
        st_finish:
        begin
          // csn held 2 more clk after the last falling edge
          fin_wait <= 1'b1;
          if (fin_wait)
          begin
            adxl_csn <= 1'b1;
            state    <= st_idle;
          end
        end
        default:
          state <= st_idle;
      endcase
    end
  end

endmodule

// File: hdl/sample_ring.sv
`timescale 1ns/100ps
// circular byte ram for sensor samples
// wrapping write pointer, registered read port
`include "adxl_log_consts.svh"

module sample_ring
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    wr,       // write strobe
  input  adxl_log_pkg::byte_t     wr_data,
  input  adxl_log_pkg::ram_addr_t rd_addr,
  output adxl_log_pkg::byte_t     rd_data,  // 1 clk after rd_addr
  output adxl_log_pkg::ram_addr_t wr_ptr    // next slot to write
);

  localparam adxl_log_pkg::ram_addr_t ram_top =
    adxl_log_pkg::ram_addr_t'(`ADXL_RAM_LEN - 1);

  adxl_log_pkg::byte_t mem [0:`ADXL_RAM_LEN-1];

  // pointer wraps, oldest data gets overwritten
  always_ff @(posedge clk)
  begin
    if (reset)
      wr_ptr <= '0;
    else if (wr)
      wr_ptr <= (wr_ptr == ram_top) ? '0 : wr_ptr + 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (wr)
      mem[wr_ptr] <= wr_data;
    rd_data <= mem[rd_addr];
  end

endmodule

// File: hdl/host_spi_slave.sv
`timescale 1ns/100ps
// host spi slave, mode 0, oversampled on clk
// frame: command, address high, address low, then response bytes
// responses are ram stream, write pointer or pps count, else 8'hff
`include "adxl_log_consts.svh"

module host_spi_slave
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    host_csn,
  input  logic                    host_sclk,  // below clk/8
  input  logic                    host_mosi,
  input  adxl_log_pkg::byte_t     rd_data,
  input  adxl_log_pkg::ram_addr_t wr_ptr,
  input  logic [15:0]             pps_count,
  output logic                    host_miso,
  output adxl_log_pkg::ram_addr_t rd_addr
);

  localparam adxl_log_pkg::ram_addr_t ram_len_a =
    adxl_log_pkg::ram_addr_t'(`ADXL_RAM_LEN);
  localparam adxl_log_pkg::ram_addr_t ram_top =
    adxl_log_pkg::ram_addr_t'(`ADXL_RAM_LEN - 1);

  logic [1:0]                csn_s;
  logic [2:0]                sclk_s;     // 2 sync flops + edge history
  logic [1:0]                mosi_s;
  logic                      active;
  logic                      sclk_rise;
  logic                      sclk_fall;
  logic [2:0]                bit_cnt;
  logic [1:0]                byte_cnt;   // 3 means response phase
  logic                      resp_lo;    // next status byte is the low one
  adxl_log_pkg::byte_t       rx_sr;
  adxl_log_pkg::byte_t       rx_byte;
  adxl_log_pkg::byte_t       addr_hi;
  adxl_log_pkg::byte_t       tx_sr;
  adxl_log_pkg::byte_t       resp_byte;
  adxl_log_pkg::host_cmd_e   cmd;
  logic [15:0]               addr_word;
  logic [15:0]               stat_word;  // snapshot for ptr/pps reads
  adxl_log_pkg::ram_addr_t   start_addr;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      csn_s  <= 2'b11;
      sclk_s <= '0;
      mosi_s <= '0;
    end
    else
    begin
      csn_s  <= {csn_s[0], host_csn};
      sclk_s <= {sclk_s[1:0], host_sclk};
      mosi_s <= {mosi_s[0], host_mosi};
    end
  end

  assign active    = ~csn_s[1];
  assign sclk_rise = sclk_s[1] & ~sclk_s[2];
  assign sclk_fall = ~sclk_s[1] & sclk_s[2];
  assign rx_byte   = {rx_sr[6:0], mosi_s[1]}; // byte as of this rising edge
  assign addr_word = {addr_hi, rx_byte};
  // addresses past the ram fold back into range
  assign start_addr = (addr_word[`ADXL_ADDR_BITS-1:0] >= ram_len_a) ?
                      addr_word[`ADXL_ADDR_BITS-1:0] - ram_len_a :
                      addr_word[`ADXL_ADDR_BITS-1:0];

  always_comb
  begin
    case (cmd)
      adxl_log_pkg::cmd_ram: resp_byte = rd_data;
      adxl_log_pkg::cmd_ptr,
      adxl_log_pkg::cmd_pps: resp_byte = resp_lo ? stat_word[7:0] : stat_word[15:8];
      default:               resp_byte = 8'hff;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      bit_cnt  <= '0;
      byte_cnt <= '0;
      resp_lo  <= 1'b0;
      tx_sr    <= '0;
      rd_addr  <= '0;
    end
    else if (!active)
    begin
      bit_cnt  <= '0; // frame restarts on next csn fall
      byte_cnt <= '0;
      resp_lo  <= 1'b0;
      tx_sr    <= '0;   // miso low between frames
    end
    else
    begin
      if (sclk_rise)
      begin
        rx_sr   <= rx_byte;
        bit_cnt <= bit_cnt + 1'b1;
        if (bit_cnt == 3'd7)
        begin
          case (byte_cnt)
            2'd0: cmd     <= adxl_log_pkg::host_cmd_e'(rx_byte);
            2'd1: addr_hi <= rx_byte;
            2'd2:
            begin
              // first response gets fetched here, ahead of the falling edge
              if (cmd == adxl_log_pkg::cmd_ram)
                rd_addr <= start_addr;
              stat_word <= (cmd == adxl_log_pkg::cmd_ptr) ? 16'(wr_ptr) : pps_count;
            end
            default:
              if (cmd == adxl_log_pkg::cmd_ram)
                rd_addr <= (rd_addr == ram_top) ? '0 : rd_addr + 1'b1;
          endcase
          if (byte_cnt != 2'd3)
            byte_cnt <= byte_cnt + 1'b1;
        end
      end
      if (sclk_fall)
      begin
        if (bit_cnt == 3'd0 && byte_cnt == 2'd3)
        begin
          tx_sr   <= resp_byte; // msb valid before the next rising edge
          resp_lo <= ~resp_lo;  // status pair repeats on longer reads
        end
        else
          tx_sr <= {tx_sr[6:0], 1'b0};
      end
    end
  end

  assign host_miso = tx_sr[7];

endmodule

// File: hdl/adxl_log_top.sv
`timescale 1ns/100ps
// adxl355 logger top
// sample clock, sensor reader, sample ring and host spi port

module adxl_log_top
(
  input  logic clk,
  input  logic reset,
  input  logic pps,         // host time reference
  // adxl355
  output logic drdy,        // sensor sync input
  output logic adxl_csn,
  output logic adxl_sclk,
  output logic adxl_mosi,
  input  logic adxl_miso,
  // esp32 host
  input  logic host_csn,
  input  logic host_sclk,
  input  logic host_mosi,
  output logic host_miso
);

  logic                    sync_pulse;
  logic [15:0]             pps_count;
  logic                    wr;
  adxl_log_pkg::byte_t     wr_data;
  adxl_log_pkg::byte_t     rd_data;
  adxl_log_pkg::ram_addr_t rd_addr;
  adxl_log_pkg::ram_addr_t wr_ptr;

  sync_nco i_sync_nco
  (
    .clk        (clk),
    .reset      (reset),
    .pps        (pps),
    .drdy       (drdy),
    .sync_pulse (sync_pulse),
    .pps_count  (pps_count)
  );

  adxl355_reader i_reader
  (
    .clk        (clk),
    .reset      (reset),
    .sync_pulse (sync_pulse),
    .adxl_miso  (adxl_miso),
    .adxl_csn   (adxl_csn),
    .adxl_sclk  (adxl_sclk),
    .adxl_mosi  (adxl_mosi),
    .wr         (wr),
    .wr_data    (wr_data)
  );

  sample_ring i_ring
  (
    .clk     (clk),
    .reset   (reset),
    .wr      (wr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .wr_ptr  (wr_ptr)
  );

  host_spi_slave i_host
  (
    .clk       (clk),
    .reset     (reset),
    .host_csn  (host_csn),
    .host_sclk (host_sclk),
    .host_mosi (host_mosi),
    .rd_data   (rd_data),
    .wr_ptr    (wr_ptr),
    .pps_count (pps_count),
    .host_miso (host_miso),
    .rd_addr   (rd_addr)
  );

endmodule

// File: bench/adxl355_model.sv
`timescale 1ns/100ps
// behavioral adxl355 spi slave, mode 0, msb first
// byte k of burst n reads back as n*16+k
// keeps the command byte of the last burst

module adxl355_model
(
  input  logic       csn,
  input  logic       sclk,
  input  logic       mosi,
  output logic       miso,
  output logic [7:0] last_cmd   // command seen in the last burst
);

  int         burst_idx;  // bursts started so far
  int         cur_burst;
  int         bit_idx;    // falling edges since csn fell
  logic [7:0] cmd_sr;

  function automatic logic [7:0] pattern_byte(input int n, input int k);
    return 8'((n * 16 + k) % 256);
  endfunction

  initial
  begin
    miso      = 1'b0;
    last_cmd  = 8'h00;
    burst_idx = 0;
    cur_burst = 0;
    bit_idx   = 0;
    cmd_sr    = 8'h00;
  end

  always @(negedge csn)
  begin
    cur_burst = burst_idx;
    burst_idx = burst_idx + 1;
    bit_idx   = 0;
    miso     <= 1'b0;  // command phase, nothing to return
  end

  // command bits on the rising edge
  always @(posedge sclk)
  begin
    if (csn == 1'b0 && bit_idx < 8)
      cmd_sr <= {cmd_sr[6:0], mosi};
  end

  // next data bit goes out on each falling edge
  always @(negedge sclk)
  begin
    logic [7:0] data;
    if (csn == 1'b0)
    begin
      bit_idx = bit_idx + 1;
      if (bit_idx == 8)
        last_cmd <= cmd_sr;
      if (bit_idx >= 8 && bit_idx < 80) // 9 data bytes after the command
      begin
        data = pattern_byte(cur_burst, bit_idx / 8 - 1) << (bit_idx % 8);
        miso <= data[7];
      end
      else
        miso <= 1'b0;
    end
  end

endmodule

// File: bench/tb_adxl_log_top.sv
`timescale 1ns/100ps
// testbench for the adxl355 logger top
// table of host spi reads applied in a loop, sensor model as data source
// expected bytes from the burst pattern, xorshift start addresses
`include "adxl_log_consts.svh"

module tb_adxl_log_top;

  localparam logic [2:0] rule_zero = 3'd0;  // all bytes 0
  localparam logic [2:0] rule_ptr  = 3'd1;  // 6 bytes per finished burst
  localparam logic [2:0] rule_ram  = 3'd2;  // pattern with every third byte skipped
  localparam logic [2:0] rule_pps  = 3'd3;  // 10 samples +-1 per 5120 clk
  localparam logic [2:0] rule_ff   = 3'd4;  // unknown command
  localparam int num_tests     = 12;
  localparam int burst_timeout = 2000;      // clk, bursts come every 1024
  localparam int sample_period = 512;       // clk per drdy cycle, 65536 / ADXL_PA_INC

  typedef struct packed {
    logic [7:0]  cmd;
    logic [15:0] addr;
    logic [7:0]  count;      // response bytes
    logic [3:0]  bursts;     // finished bursts to wait for first
    logic [2:0]  rule;
    logic        rand_addr;  // start address from xorshift
  } test_t;

  logic        clk;
  logic        reset;
  logic        pps;
  logic        drdy;
  logic        adxl_csn;
  logic        adxl_sclk;
  logic        adxl_mosi;
  logic        adxl_miso;
  logic        host_csn;
  logic        host_sclk;
  logic        host_mosi;
  logic        host_miso;
  logic [7:0]  sensor_cmd;
  test_t       tests [0:num_tests-1];
  logic [7:0]  resp [$];
  logic [31:0] rng = 32'h73d5ac44;
  logic        timed_out = 1'b0;
  int          errors = 0;
  int          checks = 0;
  int          bursts_done = 0;
  logic        drdy_q = 1'b0;
  logic        drdy_seen = 1'b0;  // a drdy rise since reset
  int          drdy_cycles = 0;   // clk since the last drdy rise

  adxl_log_top i_dut
  (
    .clk       (clk),
    .reset     (reset),
    .pps       (pps),
    .drdy      (drdy),
    .adxl_csn  (adxl_csn),
    .adxl_sclk (adxl_sclk),
    .adxl_mosi (adxl_mosi),
    .adxl_miso (adxl_miso),
    .host_csn  (host_csn),
    .host_sclk (host_sclk),
    .host_mosi (host_mosi),
    .host_miso (host_miso)
  );

  adxl355_model i_sensor
  (
    .csn      (adxl_csn),
    .sclk     (adxl_sclk),
    .mosi     (adxl_mosi),
    .miso     (adxl_miso),
    .last_cmd (sensor_cmd)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // a csn rise ends a burst
  always @(posedge adxl_csn)
    if (!reset)
      bursts_done <= bursts_done + 1;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // ram byte a: burst a/6, kept bytes 0,1,3,4,6,7 of that burst
  function automatic logic [7:0] logged_byte(input int a);
    int n;
    int j;
    int k;
    n = a / 6;
    j = a % 6;
    k = (j / 2) * 3 + (j % 2);
    return 8'((n * 16 + k) % 256);
  endfunction

  function automatic logic [7:0] expected_byte(input logic [2:0] rule, input int i,
                                               input logic [15:0] addr,
                                               input logic [15:0] ptr);
    case (rule)
      rule_ptr: return (i % 2 == 0) ? ptr[15:8] : ptr[7:0]; // high byte first
      rule_ram: return logged_byte((int'(addr) + i) % `ADXL_RAM_LEN);
      rule_ff:  return 8'hff;
      default:  return 8'h00;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  // sample clock period between drdy rises
  always @(negedge clk)
  begin
    drdy_q      <= drdy;
    drdy_cycles <= drdy_cycles + 1;
    if (reset)
      drdy_seen <= 1'b0;
    else if (drdy && !drdy_q)
    begin
      if (drdy_seen)
        check_value("drdy period", 32'(drdy_cycles + 1), 32'(sample_period));
      drdy_seen   <= 1'b1;
      drdy_cycles <= 0;
    end
  end

  task automatic wait_bursts(input int n);
    int target;
    int cycles;
    int k;
    for (k = 0; k < n && !timed_out; k++)
    begin
      target = bursts_done + 1;
      cycles = 0;
      while (bursts_done < target && cycles < burst_timeout)
      begin
        @(negedge clk);
        cycles++;
      end
      if (bursts_done < target)
      begin
        $display("timeout: sensor burst %0d did not end within %0d clock cycles",
                 target, burst_timeout);
        timed_out = 1'b1;
      end
    end
  endtask

  // one host byte, mode 0, sclk half-period 8 clk
  task automatic host_byte(input logic [7:0] tx, output logic [7:0] rx);
    logic [7:0] sr;
    sr = tx;
    rx = 8'h00;
    repeat (8)
    begin
      host_mosi = sr[7];
      sr = sr << 1;
      repeat (8) @(negedge clk);
      rx = {rx[6:0], host_miso};  // taken at the rising edge
      host_sclk = 1'b1;
      repeat (8) @(negedge clk);
      host_sclk = 1'b0;
    end
  endtask

  task automatic host_transfer(input logic [7:0] cmd, input logic [15:0] addr,
                               input int count);
    logic [7:0] rx;
    int b;
    resp.delete();
    @(negedge clk);
    host_csn = 1'b0;
    host_byte(cmd, rx);
    host_byte(addr[15:8], rx);
    host_byte(addr[7:0], rx);
    for (b = 0; b < count; b++)
    begin
      host_byte(8'h00, rx);
      resp.push_back(rx);
    end
    repeat (4) @(negedge clk);
    host_csn = 1'b1;
    repeat (16) @(negedge clk);  // gap between frames
  endtask

  task automatic pps_pair();
    pps = 1'b1;
    repeat (64) @(negedge clk);
    pps = 1'b0;
    repeat (5120 - 64) @(negedge clk); // second rise 5120 clk after the first
    pps = 1'b1;
    repeat (64) @(negedge clk);
    pps = 1'b0;
  endtask

  initial
  begin
    int          t;
    int          i;
    int          span;
    int          errs_before;
    logic [15:0] addr;
    logic [15:0] ptr_exp;
    logic [15:0] pps_got;
    logic [15:0] pps_exp;
    // cmd, addr, bytes, bursts, rule, random address
    tests[0]  = '{`HOST_CMD_PTR, 16'd0, 8'd2,  4'd0, rule_zero, 1'b0}; // right after reset
    tests[1]  = '{`HOST_CMD_PPS, 16'd0, 8'd2,  4'd0, rule_zero, 1'b0};
    tests[2]  = '{`HOST_CMD_PTR, 16'd0, 8'd2,  4'd2, rule_ptr,  1'b0};
    tests[3]  = '{`HOST_CMD_RAM, 16'd0, 8'd12, 4'd0, rule_ram,  1'b0};
    tests[4]  = '{`HOST_CMD_PTR, 16'd0, 8'd2,  4'd1, rule_ptr,  1'b0};
    tests[5]  = '{`HOST_CMD_RAM, 16'd0, 8'd12, 4'd0, rule_ram,  1'b1};
    tests[6]  = '{`HOST_CMD_RAM, 16'd0, 8'd9,  4'd1, rule_ram,  1'b1};
    tests[7]  = '{`HOST_CMD_PPS, 16'd0, 8'd2,  4'd0, rule_pps,  1'b0};
    tests[8]  = '{8'h5a,         16'd0, 8'd3,  4'd0, rule_ff,   1'b0};
    tests[9]  = '{`HOST_CMD_PTR, 16'd0, 8'd2,  4'd1, rule_ptr,  1'b0};
    tests[10] = '{`HOST_CMD_RAM, 16'd0, 8'd30, 4'd0, rule_ram,  1'b0};
    tests[11] = '{8'h00,         16'd0, 8'd2,  4'd0, rule_ff,   1'b0};
    reset     = 1'b1;
    pps       = 1'b0;
    host_csn  = 1'b1;
    host_sclk = 1'b0;
    host_mosi = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    check_value("drdy", 32'(drdy), 32'd0);
    check_value("adxl_csn", 32'(adxl_csn), 32'd1);
    check_value("host_miso", 32'(host_miso), 32'd0);
    $display("test reset idle: %0d mismatches", errors);
    t = 0;
    while (t < num_tests && !timed_out)
    begin
      errs_before = errors;
      wait_bursts(int'(tests[t].bursts));
      if (!timed_out)
      begin
        if (tests[t].bursts != 4'd0)
          check_value("adxl_mosi command", 32'(sensor_cmd), 32'(`ADXL_READ_CMD));
        addr = tests[t].addr;
        if (tests[t].rand_addr)
        begin
          span = 6 * bursts_done - int'(tests[t].count); // stay in written bytes
          rng  = xorshift32(rng);
          addr = (span > 0) ? 16'(rng % 32'(span + 1)) : 16'd0;
        end
        if (tests[t].rule == rule_pps)
          pps_pair();
        ptr_exp = 16'((6 * bursts_done) % `ADXL_RAM_LEN);
        host_transfer(tests[t].cmd, addr, int'(tests[t].count));
        if (tests[t].rule == rule_pps)
        begin
          pps_got = {resp[0], resp[1]};
          pps_exp = (pps_got < 16'd9) ? 16'd9 : ((pps_got > 16'd11) ? 16'd11 : pps_got);
          check_value("pps_count", 32'(pps_got), 32'(pps_exp));
        end
        else
          for (i = 0; i < int'(tests[t].count); i++)
            check_value($sformatf("host_miso byte %0d", i), 32'(resp[i]),
                        32'(expected_byte(tests[t].rule, i, addr, ptr_exp)));
        $display("test %0d cmd %02h addr %0d len %0d: %0d mismatches",
                 t, tests[t].cmd, addr, tests[t].count, errors - errs_before);
      end
      t++;
    end
    check_value("drdy rising", 32'(drdy_seen), 32'd1);
    $display("%0d of %0d table tests run, %0d checks, %0d errors",
             t, num_tests, checks, errors);
    if (errors == 0 && !timed_out)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

// File: adxl_log_top.f
+incdir+hdl
hdl/adxl_log_pkg.sv
hdl/sync_nco.sv
hdl/adxl355_reader.sv
hdl/sample_ring.sv
hdl/host_spi_slave.sv
hdl/adxl_log_top.sv
bench/adxl355_model.sv
bench/tb_adxl_log_top.sv

// File: run_sim.sh
#!/bin/sh
# build tb_adxl_log_top with verilator, run it, then look for the pass line in sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing -j 0 --top-module tb_adxl_log_top -f adxl_log_top.f \
  -o tb_adxl_log_top > build.log 2>&1 &&
./obj_dir/tb_adxl_log_top > sim.log 2>&1 ||
{ echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }
grep -q "^STATUS: PASS$" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }
